// File: sources.f
rv32i_types.sv
queue.sv
pc_counter.sv
fetch_fsm.sv
fetch_top.sv
tb_imem.sv
tb_fetch_top.sv

// File: Makefile
VERILATOR   ?= verilator
TB_TOP      ?= tb_fetch_top
RTL_TOP     ?= fetch_top
FILE_LIST   ?= sources.f
OBJ_DIR     ?= obj_dir
TIMESCALE   ?= 1ns/1ns
BUILD_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS  ?= --lint-only -Wall --timing
PASS_MSG    ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --timescale $(TIMESCALE) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: build
	@out="$$($(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(RTL_TOP) \
		-f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_fetch_top.sv
`timescale 1ns/1ns

module tb_fetch_top;

    import rv32i_types::*;

    localparam logic [XLEN-1:0] KEY = 32'h5a3c_96e1; // instr = pc ^ KEY
    localparam int SEED       = 20487;
    localparam int TIMEOUT    = 200;   // cycles allowed per wait
    localparam int RUN_CYCLES = 6000;

    logic            clk;
    logic            rst;
    logic            imem_req;
    logic [XLEN-1:0] imem_addr;
    logic            imem_resp;
    logic [XLEN-1:0] imem_rdata;
    logic            instr_valid;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] instr_pc;
    logic            instr_take;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;

    int errors    = 0;  // written by the monitor only
    int timeouts  = 0;  // written by the stimulus only
    int takes     = 0;
    int redirects = 0;

    // monitor state, previous cycle view
    int              in_flight = 0;   // requests minus responses
    int              issued = 0;      // requests since last redirect
    int              taken = 0;       // takes since last redirect
    logic [XLEN-1:0] exp_pc = RESET_PC;
    logic [11:0]     cur_tag = '0;    // pc[31:20] of the current stream
    logic            after_reset = 1'b1;
    logic            hold_prev = 1'b0;
    logic [XLEN-1:0] prev_instr = '0;
    logic [XLEN-1:0] prev_pc = '0;

    fetch_top i_fetch_top (
        .clk         (clk),
        .rst         (rst),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_resp   (imem_resp),
        .imem_rdata  (imem_rdata),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_take  (instr_take),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    tb_imem #(.KEY(KEY)) i_imem (
        .clk   (clk),
        .rst   (rst),
        .req   (imem_req),
        .addr  (imem_addr),
        .resp  (imem_resp),
        .rdata (imem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("FAILED %0t %s expected %h got %h", $time, name, expected, actual);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR %0t %s", $time, what);
    endtask

    // sees the cycle that just ended, same view as the DUT's registers
    always @(posedge clk)
    begin
        if (rst)
        begin
            assert (imem_req == 1'b0) else report_mismatch("imem_req", 32'd0, 32'(imem_req));
            assert (instr_valid == 1'b0)
                else report_mismatch("instr_valid", 32'd0, 32'(instr_valid));
            in_flight   = 0;
            issued      = 0;
            taken       = 0;
            exp_pc      = RESET_PC;
            cur_tag     = '0;
            after_reset = 1'b1;
            hold_prev   = 1'b0;
        end
        else
        begin
            if (after_reset)
            begin
                // first cycle out of reset must already request
                assert (imem_req == 1'b1) else report_mismatch("imem_req", 32'd1, 32'(imem_req));
                assert (imem_addr == RESET_PC)
                    else report_mismatch("imem_addr", RESET_PC, imem_addr);
                after_reset = 1'b0;
            end
            if (hold_prev)
            begin
                assert (instr_valid == 1'b1)
                    else report_mismatch("instr_valid", 32'd1, 32'(instr_valid));
                assert (instr == prev_instr) else report_mismatch("instr", prev_instr, instr);
                assert (instr_pc == prev_pc) else report_mismatch("instr_pc", prev_pc, instr_pc);
            end
            if (instr_take)
            begin
                assert (instr_valid) else report_problem("instr_take raised with nothing valid");
                assert (instr == (instr_pc ^ KEY))
                    else report_mismatch("instr", instr_pc ^ KEY, instr);
                assert (instr_pc == exp_pc) else report_mismatch("instr_pc", exp_pc, instr_pc);
                // stale words carry the tag of an older stream
                assert (instr_pc[31:20] == cur_tag)
                    else report_problem("entry fetched before a redirect was taken after it");
                exp_pc = instr_pc + 32'd4;
                taken++;
                takes++;
            end
            if (redirect)
            begin
                assert (imem_req == 1'b0) else report_mismatch("imem_req", 32'd0, 32'(imem_req));
                exp_pc  = redirect_pc;
                cur_tag = redirect_pc[31:20];
                issued  = 0;
                taken   = 0;
            end
            if (imem_req)
            begin
                in_flight++;
                issued++;
            end
            if (imem_resp)
            begin
                in_flight--;
            end
            assert (in_flight <= MAX_OUTSTANDING)
                else report_mismatch("requests in flight", 32'(MAX_OUTSTANDING), 32'(in_flight));
            assert (issued - taken <= QUEUE_DEPTH)
                else report_mismatch("issued minus taken", 32'(QUEUE_DEPTH), 32'(issued - taken));
            hold_prev  = instr_valid && !instr_take && !redirect;
            prev_instr = instr;
            prev_pc    = instr_pc;
        end
    end

    // queue is full after a long stall, one take must restart requests
    task automatic resume_after_stall();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!instr_valid && waited < TIMEOUT)
        begin
            @(posedge clk);
            waited++;
        end
        if (!instr_valid)
        begin
            timeouts++;
            $display("timeout at %0t, no instruction became valid after a stall", $time);
        end
        else
        begin
            instr_take <= 1'b1; // valid held through a cycle without take
            @(posedge clk);
            instr_take <= 1'b0;
            waited = 0;
            @(posedge clk);
            while (!imem_req && waited < TIMEOUT)
            begin
                @(posedge clk);
                waited++;
            end
            if (!imem_req)
            begin
                timeouts++;
                $display("timeout at %0t, fetching did not resume after a stall", $time);
            end
        end
    endtask

    initial
    begin
        int   roll;
        int   stall_left;
        logic can_take;
        void'($urandom(SEED));
        stall_left  = 0;
        rst         = 1'b1;
        instr_take  = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < RUN_CYCLES; n++)
        begin
            @(posedge clk);
            // valid stays up next cycle only if nothing could remove the head
            can_take = instr_valid && !instr_take && !redirect;
            if (stall_left > 0)
            begin
                instr_take <= 1'b0;
                redirect   <= 1'b0;
                stall_left--;
                if (stall_left == 0)
                begin
                    resume_after_stall();
                end
            end
            else
            begin
                roll = $urandom_range(0, 999);
                if (roll < 8)
                begin
                    redirects++;
                    // tag in pc[31:20] marks the stream, low part leaves headroom
                    redirect_pc <= {12'(redirects), 2'b00, 16'($urandom), 2'b00};
                    redirect    <= 1'b1;
                    instr_take  <= 1'b0;
                end
                else if (roll < 14)
                begin
                    stall_left = $urandom_range(30, 90); // long decode stall
                    instr_take <= 1'b0;
                    redirect   <= 1'b0;
                end
                else
                begin
                    redirect   <= 1'b0;
                    instr_take <= can_take && ($urandom_range(0, 3) != 0);
                end
            end
        end
        @(posedge clk);
        instr_take <= 1'b0;
        redirect   <= 1'b0;
        @(posedge clk);
        if (takes == 0)
        begin
            $display("no instruction was taken during the run");
        end
        $display("errors=%0d timeouts=%0d takes=%0d redirects=%0d",
                 errors, timeouts, takes, redirects);
        if (errors == 0 && timeouts == 0 && takes > 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : tb_fetch_top

// File: tb_imem.sv
`timescale 1ns/1ns

module tb_imem #(
    parameter logic [31:0] KEY = 32'h0 // data rule, word = address ^ KEY
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req,   // one-cycle request pulse
    input  logic [rv32i_types::XLEN-1:0]  addr,
    output logic                          resp,  // one-cycle response pulse
    output logic [rv32i_types::XLEN-1:0]  rdata
);

    import rv32i_types::*;

    logic [XLEN-1:0] pending_addr [$]; // requests not yet answered, oldest first
    int              pending_due [$];  // cycle each one is answered at
    int              cyc = 0;
    int              last_due = -1;    // keeps answers in order, one per cycle
    logic            resp_q = 1'b0;
    logic [XLEN-1:0] rdata_q = '0;

    assign resp  = resp_q;
    assign rdata = rdata_q;

    always @(posedge clk)
    begin
        int lat;
        int due;
        if (rst)
        begin
            pending_addr.delete();
            pending_due.delete();
            cyc      = 0;
            last_due = -1;
            resp_q  <= 1'b0;
        end
        else
        begin
            cyc++;
            if (req)
            begin
                lat = $urandom_range(1, 6);  // request cycle to response cycle
                due = cyc + lat - 1;
                if (due <= last_due)
                begin
                    due = last_due + 1;      // never overtake an older request
                end
                pending_addr.push_back(addr);
                pending_due.push_back(due);
                last_due = due;
            end
            if (pending_due.size() > 0 && pending_due[0] <= cyc)
            begin
                resp_q  <= 1'b1;
                rdata_q <= pending_addr.pop_front() ^ KEY;
                void'(pending_due.pop_front());
            end
            else
            begin
                resp_q <= 1'b0; // rdata keeps its last value
            end
        end
    end

endmodule : tb_imem

// File: fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
    input  logic                          clk,
    input  logic                          rst,
    // instruction memory
    output logic                          imem_req,
    output logic [rv32i_types::XLEN-1:0]  imem_addr,
    input  logic                          imem_resp,
    input  logic [rv32i_types::XLEN-1:0]  imem_rdata,
    // decode
    output logic                          instr_valid,
    output logic [rv32i_types::XLEN-1:0]  instr,
    output logic [rv32i_types::XLEN-1:0]  instr_pc,
    input  logic                          instr_take,
    // later stages
    input  logic                          redirect,
    input  logic [rv32i_types::XLEN-1:0]  redirect_pc
);

    import rv32i_types::*;

    logic [XLEN-1:0]      pc;
    logic                 pc_step;
    logic                 pc_load;
    logic                 pcq_enqueue;
    logic                 pcq_dequeue;
    logic                 pcq_full;
    logic                 pcq_empty;
    logic [PCQ_CNT_W-1:0] pcq_count;
    logic [XLEN-1:0]      pcq_head;   // address of oldest outstanding request
    logic                 iq_enqueue;
    logic                 iq_flush;
    logic                 iq_empty;
    logic [IQ_CNT_W-1:0]  iq_count;
    fetch_entry_t         iq_wdata;
    fetch_entry_t         iq_head;

    pc_counter i_pc_counter (
        .clk     (clk),
        .rst     (rst),
        .step    (pc_step),
        .load    (pc_load),
        .load_pc (redirect_pc),
        .pc      (pc)
    );

    fetch_fsm i_fetch_fsm (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .imem_resp   (imem_resp),
        .pcq_full    (pcq_full),
        .pcq_empty   (pcq_empty),
        .pcq_count   (pcq_count),
        .iq_count    (iq_count),
        .imem_req    (imem_req),
        .pc_step     (pc_step),
        .pc_load     (pc_load),
        .pcq_enqueue (pcq_enqueue),
        .pcq_dequeue (pcq_dequeue),
        .iq_enqueue  (iq_enqueue),
        .iq_flush    (iq_flush)
    );

    // pcs of requests in flight, never flushed, drained by responses
    queue #(
        .T     (logic [XLEN-1:0]),
        .DEPTH (MAX_OUTSTANDING)
    ) pc_queue (
        .clk        (clk),
        .rst        (rst),
        .wdata_in   (pc),
        .enqueue_in (pcq_enqueue),
        .dequeue_in (pcq_dequeue),
        .flush_in   (1'b0),
        .rdata_out  (pcq_head),
        .full_out   (pcq_full),
        .empty_out  (pcq_empty),
        .count_out  (pcq_count)
    );

    // response paired with the pc it answers
    assign iq_wdata = '{pc: pcq_head, instr: imem_rdata};

    queue #(
        .T     (fetch_entry_t),
        .DEPTH (QUEUE_DEPTH)
    ) instr_queue (
        .clk        (clk),
        .rst        (rst),
        .wdata_in   (iq_wdata),
        .enqueue_in (iq_enqueue),
        .dequeue_in (instr_take),
        .flush_in   (iq_flush),
        .rdata_out  (iq_head),
        .full_out   (),         // credit keeps it from filling past demand
        .empty_out  (iq_empty),
        .count_out  (iq_count)
    );

    assign imem_addr   = pc;
    assign instr_valid = !iq_empty;
    assign instr       = iq_head.instr;
    assign instr_pc    = iq_head.pc;

endmodule : fetch_top

// File: fetch_fsm.sv
`timescale 1ns/1ns

module fetch_fsm (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               redirect,
    input  logic                               imem_resp,
    input  logic                               pcq_full,
    input  logic                               pcq_empty,
    input  logic [rv32i_types::PCQ_CNT_W-1:0]  pcq_count,  // requests in flight
    input  logic [rv32i_types::IQ_CNT_W-1:0]   iq_count,   // entries waiting for decode
    output logic                               imem_req,
    output logic                               pc_step,
    output logic                               pc_load,
    output logic                               pcq_enqueue,
    output logic                               pcq_dequeue,
    output logic                               iq_enqueue,
    output logic                               iq_flush
);

    import rv32i_types::*;

    localparam int USE_W = IQ_CNT_W + 1; // room for both counts summed

    fetch_state_t state;
    fetch_state_t state_next;

    logic [USE_W-1:0] in_use;    // slots already promised
    logic             credit_ok;
    logic             last_resp; // final outstanding response this edge
    logic             drained;   // nothing in flight after this edge
    logic             issue;

    // every in-flight request already owns an instruction queue slot
    assign in_use    = USE_W'(pcq_count) + USE_W'(iq_count);
    assign credit_ok = (in_use < USE_W'(QUEUE_DEPTH)) && !pcq_full;

    assign last_resp = imem_resp && (pcq_count == PCQ_CNT_W'(1));
    assign drained   = pcq_empty || last_resp;

    // nothing issued while held in reset or on a redirect cycle
    assign issue = !rst && (state == FETCH) && !redirect && credit_ok;

    assign imem_req    = issue;
    assign pc_step     = issue;      // pc moves past the word just requested
    assign pcq_enqueue = issue;      // remember its address
    assign pc_load     = redirect;
    assign pcq_dequeue = imem_resp;  // every response retires one pc, kept or not
    // stale responses from before the redirect are dropped
    assign iq_enqueue  = imem_resp && (state == FETCH) && !redirect;
    assign iq_flush    = redirect;

    always_comb
    begin
        state_next = state;
        case (state)
            FETCH:
            begin
                if (redirect && !drained)
                begin
                    state_next = DRAIN; // old words still coming
                end
            end
            DRAIN:
            begin
                if (drained)
                begin
                    state_next = FETCH; // resume at the redirect target
                end
            end
            default: state_next = FETCH;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= FETCH;
        end
        else
        begin
            state <= state_next;
        end
    end

    // a request right after a redirect with words in flight would pair with a stale pc
    a_no_req_drain : assert property (
        @(posedge clk) disable iff (rst)
        redirect && !drained |=> !imem_req
    ) else $error("fetch_fsm: request issued while draining");

endmodule : fetch_fsm

// File: pc_counter.sv
`timescale 1ns/1ns

module pc_counter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          step,    // one request issued
    input  logic                          load,    // redirect
    input  logic [rv32i_types::XLEN-1:0]  load_pc,
    output logic [rv32i_types::XLEN-1:0]  pc
);

    import rv32i_types::*;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc <= RESET_PC;
        end
        else if (load)
        begin
            pc <= load_pc; // redirect wins over step
        end
        else if (step)
        begin
            pc <= pc + XLEN'(4); // next sequential word
        end
    end

    // no compressed or misaligned targets, redirect source must respect that
    a_pc_aligned : assert property (
        @(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00
    ) else $error("pc_counter: pc not word aligned");

endmodule : pc_counter

// File: queue.sv
`timescale 1ns/1ns

module queue #(
    parameter type T    = logic [31:0], // payload, any packed type
    parameter int DEPTH = 4             // power of two, at least 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  T                     wdata_in,
    input  logic                 enqueue_in,
    input  logic                 dequeue_in,
    input  logic                 flush_in,
    output T                     rdata_out,
    output logic                 full_out,
    output logic                 empty_out,
    output logic [$clog2(DEPTH):0] count_out
);

    localparam int AW = $clog2(DEPTH); // index bits, pointer has one more

    // storage
    T mem [DEPTH];

    // pointers with wrap bit on top
    logic [AW:0]   head_reg;
    logic [AW:0]   tail_reg;
    logic [AW-1:0] head_idx;
    logic [AW-1:0] tail_idx;

    assign head_idx = head_reg[AW-1:0];
    assign tail_idx = tail_reg[AW-1:0];

    // payload write, no clear needed
    always_ff @(posedge clk)
    begin
        if (enqueue_in)
        begin
            mem[tail_idx] <= wdata_in; // slot at tail
        end
    end

    // pointer update
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            head_reg <= '0;
            tail_reg <= '0;
        end
        else if (flush_in)
        begin
            // drop everything, enqueue in the same cycle is lost too
            head_reg <= tail_reg;
        end
        else
        begin
            if (enqueue_in)
            begin
                tail_reg <= tail_reg + (AW+1)'(1);
            end
            if (dequeue_in)
            begin
                head_reg <= head_reg + (AW+1)'(1); // both may move at once
            end
        end
    end

    // head shown without waiting for dequeue
    assign rdata_out = mem[head_idx];

    // same index, wrap bits differ -> tail lapped head
    assign full_out  = (tail_idx == head_idx) && (tail_reg[AW] != head_reg[AW]);
    // same index, same lap -> nothing stored
    assign empty_out = (tail_reg == head_reg);
    // modular difference, wrap bit keeps it exact up to DEPTH
    assign count_out = tail_reg - head_reg;

    // the producer's credit must keep a full queue from seeing a write
    a_no_enq_full : assert property (
        @(posedge clk) disable iff (rst)
        enqueue_in |-> !full_out
    ) else $error("queue: enqueue while full");

    // consumer may only pop what is there
    a_no_deq_empty : assert property (
        @(posedge clk) disable iff (rst)
        dequeue_in |-> !empty_out
    ) else $error("queue: dequeue while empty");

endmodule : queue

// File: rv32i_types.sv
package rv32i_types;

    // data and address width
    localparam int XLEN = 32;

    // decode side buffer, power of two
    localparam int QUEUE_DEPTH = 8;

    // requests in flight, also the pc queue depth
    localparam int MAX_OUTSTANDING = 4;

    // count widths carry one extra bit so a full queue fits
    localparam int PCQ_CNT_W = $clog2(MAX_OUTSTANDING) + 1;
    localparam int IQ_CNT_W  = $clog2(QUEUE_DEPTH) + 1;

    // first fetch address out of reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

    // one decoded-ready slot, pc in the upper half
    typedef struct packed {
        logic [XLEN-1:0] pc;    // address the word came from
        logic [XLEN-1:0] instr; // raw rv32i encoding
    } fetch_entry_t;

    // fetch control
    // FETCH   normal issue and pairing
    // DRAIN   old responses still in flight after a redirect
    typedef enum logic {
        FETCH = 1'b0,
        DRAIN = 1'b1
    } fetch_state_t;

endpackage : rv32i_types
